// ==== design/mul_pkg.sv ====
package mul_pkg;

    // operand and product widths of the unsigned multiplier.
    localparam int OPERAND_WIDTH = 16;
    localparam int PRODUCT_WIDTH = 2 * OPERAND_WIDTH;

    // the final adder is split into equal lookahead groups, carry rippling between them.
    localparam int CLA_GROUP_WIDTH = 4;
    localparam int CLA_GROUP_COUNT = PRODUCT_WIDTH / CLA_GROUP_WIDTH;

    // Dadda target heights, applied in order until every column holds two bits.
    localparam int DADDA_STAGES = 6;
    localparam int DADDA_HEIGHTS [DADDA_STAGES] = '{13, 9, 6, 4, 3, 2};

    typedef logic [OPERAND_WIDTH-1:0] operand_t;
    typedef logic [PRODUCT_WIDTH-1:0] product_t;

endpackage

// ==== design/cla_group.sv ====
`timescale 1ns/1ps

module cla_group
    import mul_pkg::*;
#(
    parameter int WIDTH = CLA_GROUP_WIDTH
) (
    input  logic [WIDTH-1:0] x,
    input  logic [WIDTH-1:0] y,
    input  logic             carry_in,
    output logic [WIDTH-1:0] sum,
    output logic             carry_out
);

    logic [WIDTH-1:0] gen;
    logic [WIDTH-1:0] prop;
    logic [WIDTH:0]   carry;

    assign gen  = x & y;
    assign prop = x ^ y;

    // each carry is expanded into a flat sum of products over the lower bits.
    // c[i+1] = g[i] | p[i]g[i-1] | ... | p[i]..p[0]cin
    always_comb begin
        logic lookahead;
        logic chain;
        carry[0] = carry_in;
        for (int i = 0; i < WIDTH; i++) begin
            lookahead = gen[i];
            chain     = prop[i];
            for (int j = i - 1; j >= 0; j--) begin
                lookahead = lookahead | (chain & gen[j]);
                chain     = chain & prop[j];
            end
            carry[i+1] = lookahead | (chain & carry_in);
        end
    end

    assign sum       = prop ^ carry[WIDTH-1:0];
    assign carry_out = carry[WIDTH];

endmodule

// ==== design/dadda_reduction.sv ====
`timescale 1ns/1ps

module dadda_reduction
    import mul_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  logic     in_valid,
    input  operand_t a,
    input  operand_t b,
    output product_t row_sum,
    output product_t row_carry,
    output logic     rows_valid
);

    localparam int SEL_HEIGHT = 0;
    localparam int SEL_FULL   = 1;
    localparam int SEL_HALF   = 2;
    localparam int SEL_CIN    = 3;

    function automatic logic [1:0] full_add(input logic x, input logic y, input logic z);
        return {(x & y) | (x & z) | (y & z), x ^ y ^ z};
    endfunction

    function automatic logic [1:0] half_add(input logic x, input logic y);
        return {x & y, x ^ y};
    endfunction

    // replays the Dadda schedule up to the given stage and column and returns the
    // column height at the start of that stage, its counter counts or its carries in.
    function automatic int plan_count(input int stage, input int col, input int sel);
        int height [PRODUCT_WIDTH];
        int carries;
        int excess;
        int n_full;
        int n_half;
        int target;
        for (int c = 0; c < PRODUCT_WIDTH; c++) begin
            height[c] = (c < OPERAND_WIDTH) ? c + 1 : 2 * OPERAND_WIDTH - 1 - c;
        end
        for (int s = 0; s <= stage; s++) begin
            target  = DADDA_HEIGHTS[(s < DADDA_STAGES) ? s : DADDA_STAGES - 1];
            carries = 0;
            for (int c = 0; c < PRODUCT_WIDTH; c++) begin
                excess = height[c] + carries - target;
                n_full = (excess > 0) ? excess / 2 : 0;
                n_half = (excess > 0) ? excess % 2 : 0;
                if (s == stage && c == col) begin
                    case (sel)
                        SEL_FULL: return n_full;
                        SEL_HALF: return n_half;
                        SEL_CIN:  return carries;
                        default:  return height[c];
                    endcase
                end
                height[c] = height[c] + carries - 2 * n_full - n_half;
                carries   = n_full + n_half;
            end
        end
        return 0;
    endfunction

    // column_bits[s][c][k] is bit k of column c at the start of stage s.
    wire [PRODUCT_WIDTH-1:0][OPERAND_WIDTH-1:0] column_bits [DADDA_STAGES+1];
    wire [PRODUCT_WIDTH-1:0][OPERAND_WIDTH-1:0] stage_carry [DADDA_STAGES];

    product_t sum_row;
    product_t carry_row;
    logic     spill;

    // partial products, packed from the bottom of each column.
    for (genvar c = 0; c < PRODUCT_WIDTH; c++) begin : g_pp
        localparam int LO = (c < OPERAND_WIDTH) ? 0 : c - OPERAND_WIDTH + 1;
        localparam int H0 = plan_count(0, c, SEL_HEIGHT);
        for (genvar k = 0; k < OPERAND_WIDTH; k++) begin : g_bit
            if (k < H0) begin : g_and
                assign column_bits[0][c][k] = a[k + LO] & b[c - k - LO];
            end else begin : g_zero
                assign column_bits[0][c][k] = 1'b0;
            end
        end
    end

    for (genvar s = 0; s < DADDA_STAGES; s++) begin : g_stage
        for (genvar c = 0; c < PRODUCT_WIDTH; c++) begin : g_col
            localparam int H    = plan_count(s, c, SEL_HEIGHT);
            localparam int NF   = plan_count(s, c, SEL_FULL);
            localparam int NH   = plan_count(s, c, SEL_HALF);
            localparam int CIN  = plan_count(s, c, SEL_CIN);
            localparam int USED = 3 * NF + 2 * NH;
            localparam int PASS = H - USED;
            // new column order is counter sums, untouched bits, then carries from below.
            for (genvar k = 0; k < OPERAND_WIDTH; k++) begin : g_bit
                if (k < NF) begin : g_fa
                    assign {stage_carry[s][c][k], column_bits[s+1][c][k]} =
                        full_add(column_bits[s][c][3*k], column_bits[s][c][3*k+1],
                                 column_bits[s][c][3*k+2]);
                end else if (k < NF + NH) begin : g_ha
                    assign {stage_carry[s][c][k], column_bits[s+1][c][k]} =
                        half_add(column_bits[s][c][3*NF], column_bits[s][c][3*NF+1]);
                end else if (k < NF + NH + PASS) begin : g_pass
                    assign column_bits[s+1][c][k] = column_bits[s][c][k - NF - NH + USED];
                end else if (k < NF + NH + PASS + CIN) begin : g_cin
                    assign column_bits[s+1][c][k] = stage_carry[s][c-1][k - NF - NH - PASS];
                end else begin : g_empty
                    assign column_bits[s+1][c][k] = 1'b0;
                end
                if (k >= NF + NH) begin : g_no_carry
                    assign stage_carry[s][c][k] = 1'b0;
                end
            end
        end
    end

    always_comb begin
        spill = 1'b0;
        for (int c = 0; c < PRODUCT_WIDTH; c++) begin
            sum_row[c]   = column_bits[DADDA_STAGES][c][0];
            carry_row[c] = column_bits[DADDA_STAGES][c][1];
            spill        = spill | (|column_bits[DADDA_STAGES][c][OPERAND_WIDTH-1:2]);
        end
        // carries out of the top column would be lost.
        for (int s = 0; s < DADDA_STAGES; s++) begin
            spill = spill | (|stage_carry[s][PRODUCT_WIDTH-1]);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            row_sum    <= '0;
            row_carry  <= '0;
            rows_valid <= 1'b0;
        end else begin
            rows_valid <= in_valid;
            if (in_valid) begin
                row_sum   <= sum_row;
                row_carry <= carry_row;
            end
        end
    end

    // after the last stage every column holds at most two bits.
    assert property (@(posedge clk) disable iff (!arst_n) in_valid |-> !spill);

endmodule

// ==== design/final_adder.sv ====
`timescale 1ns/1ps

module final_adder
    import mul_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  logic     rows_valid,
    input  product_t row_sum,
    input  product_t row_carry,
    output product_t product,
    output logic     out_valid
);

    logic [CLA_GROUP_COUNT:0] group_carry;
    product_t                 total;

    assign group_carry[0] = 1'b0;

    // lookahead inside each group, ripple from one group to the next.
    for (genvar g = 0; g < CLA_GROUP_COUNT; g++) begin : g_group
        cla_group #(
            .WIDTH (CLA_GROUP_WIDTH)
        ) group_i (
            .x         (row_sum[g*CLA_GROUP_WIDTH +: CLA_GROUP_WIDTH]),
            .y         (row_carry[g*CLA_GROUP_WIDTH +: CLA_GROUP_WIDTH]),
            .carry_in  (group_carry[g]),
            .sum       (total[g*CLA_GROUP_WIDTH +: CLA_GROUP_WIDTH]),
            .carry_out (group_carry[g+1])
        );
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            product   <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= rows_valid;
            if (rows_valid) begin
                product <= total;
            end
        end
    end

    // a 16 by 16 unsigned product always fits in 32 bits.
    assert property (@(posedge clk) disable iff (!arst_n)
        rows_valid |-> !group_carry[CLA_GROUP_COUNT]);

    // nothing is in flight in the pipeline right after reset.
    assert property (@(posedge clk) $rose(arst_n) |=> !out_valid);

endmodule

// ==== design/dadda_mul_top.sv ====
`timescale 1ns/1ps

module dadda_mul_top
    import mul_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  logic     in_valid,
    input  operand_t a,
    input  operand_t b,
    output product_t product,
    output logic     out_valid
);

    product_t row_sum;
    product_t row_carry;
    logic     rows_valid;

    // stage one compresses the partial products to two rows.
    dadda_reduction reduction_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_valid   (in_valid),
        .a          (a),
        .b          (b),
        .row_sum    (row_sum),
        .row_carry  (row_carry),
        .rows_valid (rows_valid)
    );

    // stage two adds the rows.
    final_adder adder_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .rows_valid (rows_valid),
        .row_sum    (row_sum),
        .row_carry  (row_carry),
        .product    (product),
        .out_valid  (out_valid)
    );

endmodule

// ==== bench/tb_dadda_mul.sv ====
`timescale 1ns/1ps

module tb_dadda_mul
    import mul_pkg::*;
;

    localparam int          HALF_PERIOD   = 50;
    localparam int          DRIVE_DELAY   = 10;
    localparam int          RESET_CYCLES  = 16;
    localparam int          RANDOM_PAIRS  = 300;
    localparam int          BURST_LENGTH  = 50;
    localparam int          GAP_CYCLES    = 200;
    localparam int          DRAIN_LIMIT   = 20;
    localparam logic [31:0] SEED          = 32'h390c719d;

    logic     clk = 1'b0;
    logic     arst_n;
    logic     in_valid;
    operand_t a;
    operand_t b;
    product_t product;
    logic     out_valid;

    // each entry is {a, b, expected product}.
    logic [63:0] exp_q [$];
    logic [63:0] entry;
    logic [31:0] lcg_state = SEED;
    product_t    last_product = '0;
    logic        prev_valid = 1'b0;
    int          cycle = 0;
    int          run_start = 0;
    int          run_len = 0;

    dadda_mul_top dut_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .a         (a),
        .b         (b),
        .product   (product),
        .out_valid (out_valid)
    );

    always #(HALF_PERIOD) clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    function automatic product_t ref_product(input operand_t x, input operand_t y);
        logic [31:0] xw;
        logic [31:0] yw;
        xw = {16'h0000, x};
        yw = {16'h0000, y};
        return xw * yw;
    endfunction

    function automatic operand_t next_operand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:16];
    endfunction

    task automatic value_error(input string msg);
        $display("** Error at %0t ns: %s", $time, msg);
        $display("tests failed");
        $fatal(1, "wrong value from the DUT");
    endtask

    task automatic stall_error(input string msg);
        $display("%s", msg);
        $display("tests failed");
        $fatal(1, "run stopped");
    endtask

    task automatic send_pair(input operand_t x, input operand_t y);
        @(posedge clk);
        #(DRIVE_DELAY);
        a        = x;
        b        = y;
        in_valid = 1'b1;
        exp_q.push_back({x, y, ref_product(x, y)});
    endtask

    // operands keep moving while in_valid is low, so the hold check means something.
    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #(DRIVE_DELAY);
            a        = next_operand();
            b        = next_operand();
            in_valid = 1'b0;
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        assert (exp_q.size() == 0)
            else stall_error($sformatf("out_valid never arrived for %0d pending products",
                                       exp_q.size()));
    endtask

    // outputs are read at the falling edge, half a cycle away from any register update.
    always @(negedge clk) begin
        if (!arst_n) begin
            assert (!out_valid && product == '0)
                else value_error($sformatf("reset state out_valid=%b product=%h",
                                           out_valid, product));
        end else if (out_valid) begin
            assert (exp_q.size() > 0)
                else stall_error("out_valid went high with no pair outstanding");
            entry = exp_q.pop_front();
            assert (product == entry[31:0])
                else value_error($sformatf("%h * %h expected %h got %h",
                                           entry[63:48], entry[47:32], entry[31:0], product));
            if (!prev_valid) begin
                run_start = cycle;
                run_len   = 0;
            end
            run_len++;
            last_product = product;
        end else begin
            assert (product == last_product)
                else value_error($sformatf("product moved to %h while idle, held %h",
                                           product, last_product));
        end
        prev_valid = out_valid;
    end

    initial begin
        int       burst_cycle;
        operand_t coin;
        a        = '0;
        b        = '0;
        in_valid = 1'b0;
        arst_n   = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #(DRIVE_DELAY);
        arst_n = 1'b1;
        idle(2);
        @(negedge clk);
        assert (!out_valid && product == '0)
            else value_error("pipeline not empty after reset release");

        send_pair(16'h0000, 16'hffff);
        send_pair(16'hffff, 16'h0000);
        send_pair(16'h0001, 16'hffff);
        send_pair(16'ha5c3, 16'h0001);
        send_pair(16'hffff, 16'hffff);
        for (int i = 0; i < OPERAND_WIDTH; i++) begin
            for (int j = 0; j < OPERAND_WIDTH; j++) begin
                send_pair(operand_t'(1) << i, operand_t'(1) << j);
            end
        end
        send_pair(16'hffff, 16'h8000);
        idle(1);
        wait_drain();

        for (int i = 0; i < RANDOM_PAIRS; i++) begin
            send_pair(next_operand(), next_operand());
        end
        idle(3);
        wait_drain();
        idle(3);

        send_pair(next_operand(), next_operand());
        burst_cycle = cycle;
        for (int i = 1; i < BURST_LENGTH; i++) begin
            send_pair(next_operand(), next_operand());
        end
        idle(1);
        wait_drain();
        // two register stages put the first product out two edges after its drive.
        assert (run_len == BURST_LENGTH && run_start == burst_cycle + 2)
            else value_error($sformatf("burst gave %0d results from cycle %0d, expected %0d from %0d",
                                       run_len, run_start, BURST_LENGTH, burst_cycle + 2));

        for (int i = 0; i < GAP_CYCLES; i++) begin
            coin = next_operand();
            if (coin[0]) begin
                send_pair(next_operand(), next_operand());
            end else begin
                idle(1);
            end
        end
        idle(3);
        wait_drain();
        idle(3);

        $display("all tests passed");
        $finish;
    end

endmodule

// ==== all.f ====
design/mul_pkg.sv
design/cla_group.sv
design/dadda_reduction.sv
design/final_adder.sv
design/dadda_mul_top.sv
bench/tb_dadda_mul.sv

// ==== Bender.yml ====
package:
  name: dadda_mul

sources:
  - design/mul_pkg.sv
  - design/cla_group.sv
  - design/dadda_reduction.sv
  - design/final_adder.sv
  - design/dadda_mul_top.sv
  - target: simulation
    files:
      - bench/tb_dadda_mul.sv
